//--- include/tomasulo_consts.svh
`ifndef TOMASULO_CONSTS_SVH
`define TOMASULO_CONSTS_SVH

// rob entries, also the dispatcher's starting credit count
`define ROB_DEPTH 8

// one pool slot per rob entry, so a rob credit also covers the pool
`define RS_DEPTH 8

// log2 of ROB_DEPTH
`define TAG_W 3

`define XLEN 32

// register 0 reads zero and is never renamed
`define NUM_REGS 32

`endif

//--- design/tomasulo_pkg.sv
`include "tomasulo_consts.svh"

package tomasulo_pkg;

    localparam int REG_AW = $clog2(`NUM_REGS);

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_ADDI,
        OP_LD,
        OP_ST,
        OP_BEQ
    } op_t;

    typedef logic [`TAG_W-1:0] rob_tag_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    // dest for register writers, store_src for stores
    typedef union packed {
        reg_idx_t dest;
        reg_idx_t store_src;
    } rob_reg_u;

    typedef struct packed {
        rob_tag_t         tag;
        logic [`XLEN-1:0] value;
    } cdb_msg_t;

    typedef struct packed {
        rob_tag_t         tag;
        reg_idx_t         rd;
        logic [`XLEN-1:0] value;
        logic             write;
    } commit_msg_t;

endpackage

//--- design/tomasulo_ifs.sv
`include "tomasulo_consts.svh"

// one result per cycle, valid for a single cycle
interface cdb_if import tomasulo_pkg::*; ();
    logic             valid;
    rob_tag_t         tag;
    logic [`XLEN-1:0] value;
    // beq compare outcome
    logic             taken;

    modport source (output valid, tag, value, taken);
    modport sink (input valid, tag, value, taken);
endinterface

interface rob_commit_if import tomasulo_pkg::*; ();
    logic             valid;
    rob_tag_t         tag;
    reg_idx_t         rd;
    logic [`XLEN-1:0] value;
    logic             write;
    // pulses with the retiring mispredicted beq
    logic             flush;

    modport retire (output valid, tag, rd, value, write, flush);
    modport arch (input valid, tag, rd, value, write, flush);
endinterface

//--- design/reorder_buffer.sv
`include "tomasulo_consts.svh"

module reorder_buffer import tomasulo_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc_valid,
    input  op_t                 alloc_op,
    input  rob_reg_u            alloc_reg,
    output rob_tag_t            alloc_tag,
    input  rob_tag_t            bypass_tag_a,
    input  rob_tag_t            bypass_tag_b,
    output logic                bypass_done_a,
    output logic                bypass_done_b,
    output logic [`XLEN-1:0]    bypass_value_a,
    output logic [`XLEN-1:0]    bypass_value_b,
    cdb_if.sink                 cdb,
    input  logic [`XLEN-1:0]    store_data,
    rob_commit_if.retire        commit,
    output logic                data_read,
    output logic                data_write,
    output logic [`XLEN-1:0]    data_addr,
    output logic [`XLEN-1:0]    data_wdata,
    input  logic [`XLEN-1:0]    data_rdata,
    input  logic                data_resp,
    output logic [`TAG_W:0]     credit_return
);
    localparam int CNT_W = `TAG_W + 1;

    logic             entry_valid [`ROB_DEPTH];
    logic             entry_done [`ROB_DEPTH];
    logic             entry_taken [`ROB_DEPTH];
    op_t              entry_op [`ROB_DEPTH];
    rob_reg_u         entry_reg [`ROB_DEPTH];
    logic [`XLEN-1:0] entry_value [`ROB_DEPTH];
    logic [`XLEN-1:0] entry_sdata [`ROB_DEPTH];

    rob_tag_t         head;
    rob_tag_t         tail;
    logic [CNT_W-1:0] count;

    commit_msg_t      commit_q;
    logic             commit_valid_q;
    logic             flush_q;

    op_t              head_op;
    logic             head_ready;
    logic             head_mem;
    logic             retire;

    assign alloc_tag = tail;

    // a load is done once its address is known, its data only exists at commit
    assign bypass_done_a = entry_valid[bypass_tag_a] && entry_done[bypass_tag_a]
                           && entry_op[bypass_tag_a] != OP_LD;
    assign bypass_done_b = entry_valid[bypass_tag_b] && entry_done[bypass_tag_b]
                           && entry_op[bypass_tag_b] != OP_LD;
    assign bypass_value_a = entry_value[bypass_tag_a];
    assign bypass_value_b = entry_value[bypass_tag_b];

    assign head_op = entry_op[head];
    // head holds still during the flush cycle
    assign head_ready = entry_valid[head] && entry_done[head] && !flush_q;
    assign head_mem = head_op == OP_LD || head_op == OP_ST;
    assign retire = head_ready && (!head_mem || data_resp);

    // request held with stable address and data until data_resp
    assign data_read = head_ready && head_op == OP_LD;
    assign data_write = head_ready && head_op == OP_ST;
    assign data_addr = entry_value[head];
    assign data_wdata = entry_sdata[head];

    assign commit.valid = commit_valid_q;
    assign commit.tag = commit_q.tag;
    assign commit.rd = commit_q.rd;
    assign commit.value = commit_q.value;
    assign commit.write = commit_q.write;
    assign commit.flush = flush_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entry_valid[i] <= 1'b0;
            end
            head <= '0;
            tail <= '0;
            count <= '0;
            commit_valid_q <= 1'b0;
            flush_q <= 1'b0;
            credit_return <= '0;
        end else begin
            commit_valid_q <= retire;
            flush_q <= retire && head_op == OP_BEQ && entry_taken[head];
            credit_return <= CNT_W'(retire);

            // completion, store data rides along with the address
            if (cdb.valid && entry_valid[cdb.tag]) begin
                entry_done[cdb.tag] <= 1'b1;
                entry_value[cdb.tag] <= cdb.value;
                entry_taken[cdb.tag] <= cdb.taken;
                entry_sdata[cdb.tag] <= store_data;
            end

            if (retire) begin
                entry_valid[head] <= 1'b0;
                head <= head + 1'b1;
                commit_q.tag <= head;
                commit_q.rd <= entry_reg[head].dest;
                commit_q.value <= (head_op == OP_LD) ? data_rdata : entry_value[head];
                commit_q.write <= head_op != OP_ST && head_op != OP_BEQ
                                  && entry_reg[head].dest != '0;
            end

            if (flush_q) begin
                // drop everything younger than the branch, incl. this cycle's dispatch
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    entry_valid[i] <= 1'b0;
                end
                tail <= head;
                count <= '0;
                credit_return <= count + CNT_W'(alloc_valid);
            end else begin
                if (alloc_valid) begin
                    entry_valid[tail] <= 1'b1;
                    entry_done[tail] <= 1'b0;
                    entry_op[tail] <= alloc_op;
                    entry_reg[tail] <= alloc_reg;
                    tail <= tail + 1'b1;
                end
                count <= count + CNT_W'(alloc_valid) - CNT_W'(retire);
            end
        end
    end

endmodule

//--- design/reg_status_file.sv
`include "tomasulo_consts.svh"

module reg_status_file import tomasulo_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                rename_valid,
    input  reg_idx_t            rename_rd,
    input  rob_tag_t            rename_tag,
    input  reg_idx_t            src_a,
    input  reg_idx_t            src_b,
    output logic                busy_a,
    output logic                busy_b,
    output rob_tag_t            tag_a,
    output rob_tag_t            tag_b,
    output logic [`XLEN-1:0]    value_a,
    output logic [`XLEN-1:0]    value_b,
    rob_commit_if.arch          commit
);
    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             busy [`NUM_REGS];
    // youngest in-flight writer of each register
    rob_tag_t         producer [`NUM_REGS];

    assign busy_a = busy[src_a];
    assign busy_b = busy[src_b];
    assign tag_a = producer[src_a];
    assign tag_b = producer[src_b];
    assign value_a = regs[src_a];
    assign value_b = regs[src_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
                busy[i] <= 1'b0;
            end
        end else begin
            if (commit.valid && commit.write) begin
                regs[commit.rd] <= commit.value;
                // a younger rename keeps the register busy
                if (producer[commit.rd] == commit.tag) begin
                    busy[commit.rd] <= 1'b0;
                end
            end

            // committed values are the restored state
            if (commit.flush) begin
                for (int i = 0; i < `NUM_REGS; i++) begin
                    busy[i] <= 1'b0;
                end
            end else if (rename_valid && rename_rd != '0) begin
                busy[rename_rd] <= 1'b1;
                producer[rename_rd] <= rename_tag;
            end
        end
    end

endmodule

//--- design/reservation_station.sv
`include "tomasulo_consts.svh"

module reservation_station import tomasulo_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  op_t                 dispatch_op,
    input  logic [`XLEN-1:0]    dispatch_imm,
    input  reg_idx_t            dispatch_rs1,
    input  reg_idx_t            dispatch_rs2,
    input  rob_tag_t            dispatch_tag,
    output reg_idx_t            src_a,
    output reg_idx_t            src_b,
    input  logic                busy_a,
    input  logic                busy_b,
    input  rob_tag_t            tag_a,
    input  rob_tag_t            tag_b,
    input  logic [`XLEN-1:0]    value_a,
    input  logic [`XLEN-1:0]    value_b,
    output rob_tag_t            bypass_tag_a,
    output rob_tag_t            bypass_tag_b,
    input  logic                bypass_done_a,
    input  logic                bypass_done_b,
    input  logic [`XLEN-1:0]    bypass_value_a,
    input  logic [`XLEN-1:0]    bypass_value_b,
    input  logic                flush,
    rob_commit_if.arch          commit,
    cdb_if.source               cdb,
    output logic [`XLEN-1:0]    store_data
);
    // slot index is the rob tag, the pool is as deep as the rob
    logic             ent_valid [`RS_DEPTH];
    op_t              ent_op [`RS_DEPTH];
    logic [`XLEN-1:0] ent_imm [`RS_DEPTH];
    logic [`TAG_W-1:0] ent_age [`RS_DEPTH];
    logic             rdy_a [`RS_DEPTH];
    logic             rdy_b [`RS_DEPTH];
    rob_tag_t         wait_a [`RS_DEPTH];
    rob_tag_t         wait_b [`RS_DEPTH];
    logic [`XLEN-1:0] opnd_a [`RS_DEPTH];
    logic [`XLEN-1:0] opnd_b [`RS_DEPTH];

    cdb_msg_t         cdb_q;
    logic             cdb_valid_q;
    logic             cdb_taken_q;
    // set when the broadcast value is a register result
    logic             cdb_wake_q;
    logic [`XLEN-1:0] store_data_q;

    logic [`XLEN:0]   res_a;
    logic [`XLEN:0]   res_b;
    logic             uses_b;
    logic             issue_valid;
    rob_tag_t         issue_idx;
    op_t              issue_op;
    logic [`XLEN-1:0] iss_a;
    logic [`XLEN-1:0] iss_b;
    logic [`XLEN-1:0] alu_result;
    logic             alu_taken;

    function automatic logic cdb_hit(input rob_tag_t tag);
        return cdb_valid_q && cdb_wake_q && cdb_q.tag == tag;
    endfunction

    // load data only appears at commit
    function automatic logic commit_hit(input rob_tag_t tag);
        return commit.valid && commit.tag == tag;
    endfunction

    // {ready, value} for a source at dispatch
    function automatic logic [`XLEN:0] resolve(
        input logic             busy,
        input rob_tag_t         tag,
        input logic [`XLEN-1:0] rf_value,
        input logic             done,
        input logic [`XLEN-1:0] rob_value
    );
        if (!busy) return {1'b1, rf_value};
        if (cdb_hit(tag)) return {1'b1, cdb_q.value};
        if (commit_hit(tag)) return {1'b1, commit.value};
        if (done) return {1'b1, rob_value};
        return {1'b0, rf_value};
    endfunction

    assign src_a = dispatch_rs1;
    assign src_b = dispatch_rs2;
    assign bypass_tag_a = tag_a;
    assign bypass_tag_b = tag_b;
    assign uses_b = !(dispatch_op inside {OP_ADDI, OP_LD});

    always_comb begin
        res_a = resolve(busy_a, tag_a, value_a, bypass_done_a, bypass_value_a);
        res_b = resolve(busy_b, tag_b, value_b, bypass_done_b, bypass_value_b);
    end

    // oldest ready entry wins
    always_comb begin
        issue_valid = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (ent_valid[i] && rdy_a[i] && rdy_b[i]
                && (!issue_valid || ent_age[i] > ent_age[issue_idx])) begin
                issue_valid = 1'b1;
                issue_idx = rob_tag_t'(i);
            end
        end
    end

    assign issue_op = ent_op[issue_idx];
    assign iss_a = opnd_a[issue_idx];
    assign iss_b = opnd_b[issue_idx];

    always_comb begin
        alu_taken = 1'b0;
        case (issue_op)
            OP_ADD: alu_result = iss_a + iss_b;
            OP_SUB: alu_result = iss_a - iss_b;
            OP_AND: alu_result = iss_a & iss_b;
            OP_XOR: alu_result = iss_a ^ iss_b;
            OP_BEQ: begin
                alu_result = '0;
                alu_taken = iss_a == iss_b;
            end
            // addi, and the address of ld and st
            default: alu_result = iss_a + ent_imm[issue_idx];
        endcase
    end

    assign cdb.valid = cdb_valid_q;
    assign cdb.tag = cdb_q.tag;
    assign cdb.value = cdb_q.value;
    assign cdb.taken = cdb_taken_q;
    assign store_data = store_data_q;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                ent_valid[i] <= 1'b0;
            end
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= issue_valid;
            if (issue_valid) begin
                cdb_q.tag <= issue_idx;
                cdb_q.value <= alu_result;
                cdb_taken_q <= alu_taken;
                cdb_wake_q <= !(issue_op inside {OP_LD, OP_ST, OP_BEQ});
                store_data_q <= iss_b;
                ent_valid[issue_idx] <= 1'b0;
            end

            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (!rdy_a[i] && cdb_hit(wait_a[i])) begin
                    rdy_a[i] <= 1'b1;
                    opnd_a[i] <= cdb_q.value;
                end else if (!rdy_a[i] && commit_hit(wait_a[i])) begin
                    rdy_a[i] <= 1'b1;
                    opnd_a[i] <= commit.value;
                end
                if (!rdy_b[i] && cdb_hit(wait_b[i])) begin
                    rdy_b[i] <= 1'b1;
                    opnd_b[i] <= cdb_q.value;
                end else if (!rdy_b[i] && commit_hit(wait_b[i])) begin
                    rdy_b[i] <= 1'b1;
                    opnd_b[i] <= commit.value;
                end
                if (dispatch_valid) begin
                    ent_age[i] <= ent_age[i] + 1'b1;
                end
            end

            if (dispatch_valid) begin
                ent_valid[dispatch_tag] <= 1'b1;
                ent_op[dispatch_tag] <= dispatch_op;
                ent_imm[dispatch_tag] <= dispatch_imm;
                ent_age[dispatch_tag] <= '0;
                rdy_a[dispatch_tag] <= res_a[`XLEN];
                opnd_a[dispatch_tag] <= res_a[`XLEN-1:0];
                wait_a[dispatch_tag] <= tag_a;
                rdy_b[dispatch_tag] <= res_b[`XLEN] || !uses_b;
                opnd_b[dispatch_tag] <= res_b[`XLEN-1:0];
                wait_b[dispatch_tag] <= tag_b;
            end
        end
    end

endmodule

//--- design/tomasulo_core.sv
`include "tomasulo_consts.svh"

module tomasulo_core import tomasulo_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  op_t                 dispatch_op,
    input  reg_idx_t            dispatch_rd,
    input  reg_idx_t            dispatch_rs1,
    input  reg_idx_t            dispatch_rs2,
    input  logic [`XLEN-1:0]    dispatch_imm,
    output logic [`TAG_W:0]     dispatch_credit,
    output logic                data_read,
    output logic                data_write,
    output logic [`XLEN-1:0]    data_addr,
    output logic [`XLEN-1:0]    data_wdata,
    input  logic [`XLEN-1:0]    data_rdata,
    input  logic                data_resp,
    output logic                commit_valid,
    output reg_idx_t            commit_rd,
    output logic [`XLEN-1:0]    commit_value,
    output logic                commit_write,
    output logic                flush
);
    cdb_if        cdb_bus ();
    rob_commit_if commit_bus ();

    rob_tag_t         alloc_tag;
    rob_reg_u         alloc_reg;
    logic             rename_valid;
    reg_idx_t         src_a;
    reg_idx_t         src_b;
    logic             busy_a;
    logic             busy_b;
    rob_tag_t         tag_a;
    rob_tag_t         tag_b;
    logic [`XLEN-1:0] value_a;
    logic [`XLEN-1:0] value_b;
    rob_tag_t         bypass_tag_a;
    rob_tag_t         bypass_tag_b;
    logic             bypass_done_a;
    logic             bypass_done_b;
    logic [`XLEN-1:0] bypass_value_a;
    logic [`XLEN-1:0] bypass_value_b;
    logic [`XLEN-1:0] store_data;

    // stores carry their data register in the rob register field
    always_comb begin
        alloc_reg.dest = dispatch_rd;
        if (dispatch_op == OP_ST) begin
            alloc_reg.store_src = dispatch_rs2;
        end
    end

    assign rename_valid = dispatch_valid && dispatch_op != OP_ST && dispatch_op != OP_BEQ;

    assign commit_valid = commit_bus.valid;
    assign commit_rd = commit_bus.rd;
    assign commit_value = commit_bus.value;
    assign commit_write = commit_bus.write;
    assign flush = commit_bus.flush;

    reorder_buffer rob_i (
        .clk            (clk),
        .rst            (rst),
        .alloc_valid    (dispatch_valid),
        .alloc_op       (dispatch_op),
        .alloc_reg      (alloc_reg),
        .alloc_tag      (alloc_tag),
        .bypass_tag_a   (bypass_tag_a),
        .bypass_tag_b   (bypass_tag_b),
        .bypass_done_a  (bypass_done_a),
        .bypass_done_b  (bypass_done_b),
        .bypass_value_a (bypass_value_a),
        .bypass_value_b (bypass_value_b),
        .cdb            (cdb_bus.sink),
        .store_data     (store_data),
        .commit         (commit_bus.retire),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_rdata     (data_rdata),
        .data_resp      (data_resp),
        .credit_return  (dispatch_credit)
    );

    reg_status_file rsf_i (
        .clk          (clk),
        .rst          (rst),
        .rename_valid (rename_valid),
        .rename_rd    (dispatch_rd),
        .rename_tag   (alloc_tag),
        .src_a        (src_a),
        .src_b        (src_b),
        .busy_a       (busy_a),
        .busy_b       (busy_b),
        .tag_a        (tag_a),
        .tag_b        (tag_b),
        .value_a      (value_a),
        .value_b      (value_b),
        .commit       (commit_bus.arch)
    );

    reservation_station rs_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_imm   (dispatch_imm),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_tag   (alloc_tag),
        .src_a          (src_a),
        .src_b          (src_b),
        .busy_a         (busy_a),
        .busy_b         (busy_b),
        .tag_a          (tag_a),
        .tag_b          (tag_b),
        .value_a        (value_a),
        .value_b        (value_b),
        .bypass_tag_a   (bypass_tag_a),
        .bypass_tag_b   (bypass_tag_b),
        .bypass_done_a  (bypass_done_a),
        .bypass_done_b  (bypass_done_b),
        .bypass_value_a (bypass_value_a),
        .bypass_value_b (bypass_value_b),
        .flush          (commit_bus.flush),
        .commit         (commit_bus.arch),
        .cdb            (cdb_bus.source),
        .store_data     (store_data)
    );

endmodule

//--- verification/tomasulo_core_tb.sv
`include "tomasulo_consts.svh"

module tomasulo_core_tb import tomasulo_pkg::*; ();

    localparam int RESUME_ROW = 20;
    localparam int STALL_LIMIT = 100;
    localparam int DRAIN_LIMIT = 300;

    typedef struct packed {
        op_t              op;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic [`XLEN-1:0] imm;
    } row_t;

    logic             clk = 1'b0;
    logic             rst;
    logic             dispatch_valid;
    op_t              dispatch_op;
    reg_idx_t         dispatch_rd;
    reg_idx_t         dispatch_rs1;
    reg_idx_t         dispatch_rs2;
    logic [`XLEN-1:0] dispatch_imm;
    logic [`TAG_W:0]  dispatch_credit;
    logic             data_read;
    logic             data_write;
    logic [`XLEN-1:0] data_addr;
    logic [`XLEN-1:0] data_wdata;
    logic [`XLEN-1:0] data_rdata;
    logic             data_resp;
    logic             commit_valid;
    reg_idx_t         commit_rd;
    logic [`XLEN-1:0] commit_value;
    logic             commit_write;
    logic             flush;

    row_t             rows [$];
    reg_idx_t         exp_rd [$];
    logic [`XLEN-1:0] exp_value [$];
    logic             exp_write [$];
    logic             exp_flush [$];
    logic             exp_mem_write [$];
    logic [`XLEN-1:0] exp_mem_addr [$];
    logic [`XLEN-1:0] exp_mem_data [$];
    // untouched words of the memory model read back their own address
    logic [`XLEN-1:0] mem [logic [`XLEN-1:0]];

    int taken_row = -1;
    int credits = `ROB_DEPTH;
    int returned = 0;
    int dispatched = 0;
    int commit_idx = 0;
    int mem_idx = 0;
    int mismatch_count = 0;
    int fail_count = 0;
    logic flush_now = 1'b0;
    logic flush_seen = 1'b0;
    logic timed_out = 1'b0;

    tomasulo_core dut_i (.*);

    always #2 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    function automatic void add_row(input op_t op, input int rd, input int rs1,
                                    input int rs2, input logic [`XLEN-1:0] imm);
        row_t r;
        r.op = op;
        r.rd = reg_idx_t'(rd);
        r.rs1 = reg_idx_t'(rs1);
        r.rs2 = reg_idx_t'(rs2);
        r.imm = imm;
        rows.push_back(r);
    endfunction

    function automatic void load_table();
        // dependent alu chain, a not-taken beq and a write to x0
        add_row(OP_ADDI, 1, 0, 0, 32'd5);
        add_row(OP_ADDI, 2, 1, 0, 32'h3a);
        add_row(OP_ADD, 3, 1, 2, 32'd0);
        add_row(OP_SUB, 4, 3, 1, 32'd0);
        add_row(OP_AND, 5, 3, 4, 32'd0);
        add_row(OP_XOR, 6, 5, 2, 32'd0);
        add_row(OP_BEQ, 0, 1, 2, 32'd0);
        add_row(OP_ADDI, 0, 6, 0, 32'd1);
        // loads and stores where a store address depends on a load
        add_row(OP_LD, 7, 0, 0, 32'h100);
        add_row(OP_ADD, 8, 7, 1, 32'd0);
        add_row(OP_ST, 0, 7, 8, 32'h100);
        add_row(OP_LD, 9, 7, 0, 32'h100);
        add_row(OP_SUB, 10, 9, 8, 32'd0);
        add_row(OP_LD, 11, 0, 0, 32'h300);
        add_row(OP_ST, 0, 0, 11, 32'h304);
        add_row(OP_LD, 12, 0, 0, 32'h304);
        // taken branch, then the wrong path
        add_row(OP_BEQ, 0, 10, 0, 32'd0);
        add_row(OP_ADDI, 1, 0, 0, 32'h7ff);
        add_row(OP_ST, 0, 0, 1, 32'h300);
        add_row(OP_ADD, 3, 1, 1, 32'd0);
        // resumed path reads back pre-branch state
        add_row(OP_ADD, 13, 1, 0, 32'd0);
        add_row(OP_LD, 14, 0, 0, 32'h300);
        add_row(OP_XOR, 15, 3, 13, 32'd0);
        add_row(OP_ADDI, 16, 15, 0, 32'hffff_ffff);
        add_row(OP_BEQ, 0, 13, 15, 32'd0);
    endfunction

    // in-order execution of the table
    task automatic build_expected();
        logic [`XLEN-1:0] regs [`NUM_REGS];
        logic [`XLEN-1:0] ref_mem [logic [`XLEN-1:0]];
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] result;
        logic             writes;
        logic             taken;
        int               i;
        for (int r = 0; r < `NUM_REGS; r++) begin
            regs[r] = '0;
        end
        i = 0;
        while (i < rows.size()) begin
            a = regs[rows[i].rs1];
            b = regs[rows[i].rs2];
            addr = a + rows[i].imm;
            result = '0;
            case (rows[i].op)
                OP_ADD: result = a + b;
                OP_SUB: result = a - b;
                OP_AND: result = a & b;
                OP_XOR: result = a ^ b;
                OP_ADDI: result = a + rows[i].imm;
                OP_LD: begin
                    result = ref_mem.exists(addr) ? ref_mem[addr] : addr;
                    exp_mem_write.push_back(1'b0);
                    exp_mem_addr.push_back(addr);
                    exp_mem_data.push_back('0);
                end
                OP_ST: begin
                    ref_mem[addr] = b;
                    exp_mem_write.push_back(1'b1);
                    exp_mem_addr.push_back(addr);
                    exp_mem_data.push_back(b);
                end
                default: ;
            endcase
            writes = rows[i].op != OP_ST && rows[i].op != OP_BEQ && rows[i].rd != 0;
            taken = rows[i].op == OP_BEQ && a == b;
            if (writes) begin
                regs[rows[i].rd] = result;
            end
            exp_rd.push_back(rows[i].rd);
            exp_value.push_back(result);
            exp_write.push_back(writes);
            exp_flush.push_back(taken);
            if (taken && i < RESUME_ROW) begin
                taken_row = i;
                i = RESUME_ROW;
            end else begin
                i++;
            end
        end
    endtask

    // advances the dispatcher one cycle and collects returned credits
    task automatic step_cycle();
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        credits += dispatch_credit;
        returned += dispatch_credit;
        flush_now = flush;
        if (flush) begin
            flush_seen = 1'b1;
        end
        if (credits > `ROB_DEPTH) begin
            $display("credit count %0d is above the ROB depth at time %0t", credits, $time);
            fail_count++;
        end
    endtask

    task automatic drive_row(input row_t r);
        dispatch_valid = 1'b1;
        dispatch_op = r.op;
        dispatch_rd = r.rd;
        dispatch_rs1 = r.rs1;
        dispatch_rs2 = r.rs2;
        dispatch_imm = r.imm;
    endtask

    // commit monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (commit_valid && commit_idx >= exp_rd.size()) begin
                $display("a commit at time %0t has no instruction left to retire", $time);
                fail_count++;
            end else if (commit_valid) begin
                check_value(commit_write, exp_write[commit_idx],
                            $sformatf("commit %0d write flag", commit_idx));
                if (exp_write[commit_idx]) begin
                    check_value(commit_rd, exp_rd[commit_idx],
                                $sformatf("commit %0d rd", commit_idx));
                    check_value(commit_value, exp_value[commit_idx],
                                $sformatf("commit %0d value", commit_idx));
                end
                check_value(flush, exp_flush[commit_idx],
                            $sformatf("commit %0d flush", commit_idx));
                commit_idx++;
            end else begin
                check_value(flush, 1'b0, "flush outside a commit");
            end
        end
    end

    // data memory with 0 to 3 cycles of response delay
    initial begin
        logic             pending;
        logic             req_write;
        logic [`XLEN-1:0] req_addr;
        logic [`XLEN-1:0] req_data;
        int               delay;
        void'($urandom(32'he268));
        pending = 1'b0;
        delay = 0;
        forever begin
            @(posedge clk);
            #1;
            data_resp = 1'b0;
            if (!rst && (data_read || data_write)) begin
                if (pending) begin
                    check_value(data_write, req_write, "request kind while waiting");
                    check_value(data_addr, req_addr, "data_addr while waiting");
                    if (data_write) begin
                        check_value(data_wdata, req_data, "data_wdata while waiting");
                    end
                end else if (mem_idx >= exp_mem_addr.size()) begin
                    $display("unexpected memory request at time %0t", $time);
                    fail_count++;
                end else begin
                    check_value(data_write, exp_mem_write[mem_idx], "request is a write");
                    check_value(data_addr, exp_mem_addr[mem_idx], "data_addr");
                    if (data_write) begin
                        check_value(data_wdata, exp_mem_data[mem_idx], "data_wdata");
                    end
                end
                if (!pending) begin
                    pending = 1'b1;
                    req_write = data_write;
                    req_addr = data_addr;
                    req_data = data_wdata;
                    delay = $urandom % 4;
                end
                if (delay == 0) begin
                    if (data_write) begin
                        mem[data_addr] = data_wdata;
                    end else begin
                        data_rdata = mem.exists(data_addr) ? mem[data_addr] : data_addr;
                    end
                    data_resp = 1'b1;
                    pending = 1'b0;
                    mem_idx++;
                end else begin
                    delay--;
                end
            end else if (pending) begin
                $display("memory request dropped before data_resp at time %0t", $time);
                fail_count++;
                pending = 1'b0;
            end
        end
    end

    initial begin
        int row;
        int stall;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op = OP_ADD;
        dispatch_rd = '0;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        dispatch_imm = '0;
        data_rdata = '0;
        data_resp = 1'b0;
        load_table();
        build_expected();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet outputs before anything is dispatched
        for (int c = 0; c < 3; c++) begin
            step_cycle();
            check_value(commit_valid, 1'b0, "idle commit_valid");
            check_value(flush, 1'b0, "idle flush");
            check_value(data_read, 1'b0, "idle data_read");
            check_value(data_write, 1'b0, "idle data_write");
            check_value(dispatch_credit, '0, "idle dispatch_credit");
        end

        // wrong-path rows go out until the flush, then resume
        row = 0;
        stall = 0;
        while (row < rows.size() && !timed_out) begin
            step_cycle();
            if (flush_now && taken_row >= 0 && row < RESUME_ROW) begin
                row = RESUME_ROW;
            end
            if (!flush_now && credits > 0
                && !(row == RESUME_ROW && taken_row >= 0 && !flush_seen)) begin
                drive_row(rows[row]);
                credits--;
                dispatched++;
                row++;
                stall = 0;
            end else begin
                stall++;
                if (stall > STALL_LIMIT) begin
                    $display("timed out dispatching row %0d with %0d credits", row, credits);
                    fail_count++;
                    timed_out = 1'b1;
                end
            end
        end

        stall = 0;
        while (commit_idx < exp_rd.size() && !timed_out) begin
            step_cycle();
            stall++;
            if (stall > DRAIN_LIMIT) begin
                $display("timed out with %0d of %0d commits seen", commit_idx, exp_rd.size());
                fail_count++;
                timed_out = 1'b1;
            end
        end

        if (!timed_out) begin
            // a few quiet cycles catch late commits and credits
            repeat (8) step_cycle();
            check_value(returned, dispatched, "credits returned after drain");
            check_value(mem_idx, exp_mem_addr.size(), "memory requests served");
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
design/tomasulo_pkg.sv
design/tomasulo_ifs.sv
design/reorder_buffer.sv
design/reg_status_file.sv
design/reservation_station.sv
design/tomasulo_core.sv
verification/tomasulo_core_tb.sv
